// ==== logic/core_pkg.sv ====
package core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;

  // first fetch address after reset
  localparam addr_t RESET_PC = 32'h0001_0000;
  // addi x0, x0, 0
  localparam inst_t NOP_INST = 32'h0000_0013;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // branch conditions
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

endpackage

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_stall_f,
  input  logic            i_stall_d,
  input  logic            i_flush_d,
  input  logic            i_jal_taken,
  input  core_pkg::addr_t i_jal_target,
  input  logic            i_br_taken,
  input  core_pkg::addr_t i_br_target,
  input  core_pkg::inst_t i_inst,
  output core_pkg::addr_t o_pc,
  output core_pkg::inst_t o_inst_d,
  output core_pkg::addr_t o_pc_d
);

  // branch from execute is older than jal in decode, so it wins
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_pc <= core_pkg::RESET_PC;
    end else if (i_br_taken) begin
      o_pc <= i_br_target;
    end else if (!i_stall_f) begin
      o_pc <= i_jal_taken ? i_jal_target : o_pc + 32'd4;
    end
  end

  // if/id register
  always_ff @(posedge clk) begin
    if (!i_rst_n || i_flush_d) begin
      o_inst_d <= core_pkg::NOP_INST;
    end else if (!i_stall_d) begin
      o_inst_d <= i_inst;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_stall_d) begin
      o_pc_d <= o_pc;
    end
  end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_flush_e,
  input  core_pkg::inst_t    i_inst_d,
  input  core_pkg::addr_t    i_pc_d,
  input  logic               i_wb_we,
  input  core_pkg::reg_idx_t i_wb_rd,
  input  core_pkg::xlen_t    i_wb_data,
  output core_pkg::reg_idx_t o_rs1_d,
  output core_pkg::reg_idx_t o_rs2_d,
  output logic               o_jal_taken,
  output core_pkg::addr_t    o_jal_target,
  output core_pkg::xlen_t    o_rs1_val_e,
  output core_pkg::xlen_t    o_rs2_val_e,
  output core_pkg::xlen_t    o_imm_e,
  output core_pkg::addr_t    o_pc_e,
  output core_pkg::reg_idx_t o_rd_e,
  output core_pkg::reg_idx_t o_rs1_e,
  output core_pkg::reg_idx_t o_rs2_e,
  output core_pkg::alu_op_e  o_alu_op_e,
  output logic               o_alu_src_imm_e,
  output logic               o_is_load_e,
  output logic               o_is_store_e,
  output logic               o_is_branch_e,
  output logic [2:0]         o_funct3_e,
  output logic               o_reg_write_e,
  output logic               o_link_e
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  core_pkg::reg_idx_t rd;
  core_pkg::xlen_t    imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  core_pkg::xlen_t    rs1_val, rs2_val;
  core_pkg::xlen_t    regs [32];
  core_pkg::alu_op_e  alu_op;
  logic               alu_src_imm, is_load, is_store, is_branch, reg_write;

  // funct3 to alu op with alt selecting sub or sra
  function automatic core_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? core_pkg::SUB : core_pkg::ADD;
      3'b001:  return core_pkg::SLL;
      3'b010:  return core_pkg::SLT;
      3'b011:  return core_pkg::SLTU;
      3'b100:  return core_pkg::XOR;
      3'b101:  return alt ? core_pkg::SRA : core_pkg::SRL;
      3'b110:  return core_pkg::OR;
      default: return core_pkg::AND;
    endcase
  endfunction

  assign opcode  = i_inst_d[6:0];
  assign funct3  = i_inst_d[14:12];
  assign rd      = i_inst_d[11:7];
  assign o_rs1_d = i_inst_d[19:15];
  assign o_rs2_d = i_inst_d[24:20];

  assign imm_i = {{20{i_inst_d[31]}}, i_inst_d[31:20]};
  assign imm_s = {{20{i_inst_d[31]}}, i_inst_d[31:25], i_inst_d[11:7]};
  assign imm_b = {{19{i_inst_d[31]}}, i_inst_d[31], i_inst_d[7], i_inst_d[30:25],
                  i_inst_d[11:8], 1'b0};
  assign imm_u = {i_inst_d[31:12], 12'b0};
  assign imm_j = {{11{i_inst_d[31]}}, i_inst_d[31], i_inst_d[19:12], i_inst_d[20],
                  i_inst_d[30:21], 1'b0};

  // jal resolves here
  assign o_jal_taken  = (opcode == core_pkg::OPC_JAL);
  assign o_jal_target = i_pc_d + imm_j;

  always_comb begin
    alu_op      = core_pkg::ADD;
    alu_src_imm = 1'b0;
    is_load     = 1'b0;
    is_store    = 1'b0;
    is_branch   = 1'b0;
    reg_write   = 1'b0;
    imm         = imm_i;
    case (opcode)
      core_pkg::OPC_OP: begin
        alu_op    = alu_from_funct(funct3, i_inst_d[30]);
        reg_write = 1'b1;
      end
      core_pkg::OPC_OP_IMM: begin
        // only srai uses bit 30 since addi has no sub form
        alu_op      = alu_from_funct(funct3, (funct3 == 3'b101) && i_inst_d[30]);
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
      end
      core_pkg::OPC_LUI: begin
        alu_op      = core_pkg::PASS_B;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        imm         = imm_u;
      end
      core_pkg::OPC_LOAD: begin
        alu_src_imm = 1'b1;
        is_load     = 1'b1;
        reg_write   = 1'b1;
      end
      core_pkg::OPC_STORE: begin
        alu_src_imm = 1'b1;
        is_store    = 1'b1;
        imm         = imm_s;
      end
      core_pkg::OPC_BRANCH: begin
        is_branch = 1'b1;
        imm       = imm_b;
      end
      core_pkg::OPC_JAL: begin
        reg_write = 1'b1;
        imm       = imm_j;
      end
      default: ;
    endcase
  end

  // register file where x0 is never written
  always_ff @(posedge clk) begin
    if (i_wb_we && i_wb_rd != '0) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  // write-through so writeback is visible the same cycle
  assign rs1_val = (o_rs1_d == '0) ? '0 :
                   (i_wb_we && i_wb_rd == o_rs1_d) ? i_wb_data : regs[o_rs1_d];
  assign rs2_val = (o_rs2_d == '0) ? '0 :
                   (i_wb_we && i_wb_rd == o_rs2_d) ? i_wb_data : regs[o_rs2_d];

  // id/ex control bits
  always_ff @(posedge clk) begin
    if (!i_rst_n || i_flush_e) begin
      o_is_load_e   <= 1'b0;
      o_is_store_e  <= 1'b0;
      o_is_branch_e <= 1'b0;
      o_reg_write_e <= 1'b0;
      o_link_e      <= 1'b0;
    end else begin
      o_is_load_e   <= is_load;
      o_is_store_e  <= is_store;
      o_is_branch_e <= is_branch;
      o_reg_write_e <= reg_write;
      o_link_e      <= o_jal_taken;
    end
  end

  // id/ex payload
  always_ff @(posedge clk) begin
    o_rs1_val_e     <= rs1_val;
    o_rs2_val_e     <= rs2_val;
    o_imm_e         <= imm;
    o_pc_e          <= i_pc_d;
    o_rd_e          <= rd;
    o_rs1_e         <= o_rs1_d;
    o_rs2_e         <= o_rs2_d;
    o_alu_op_e      <= alu_op;
    o_alu_src_imm_e <= alu_src_imm;
    o_funct3_e      <= funct3;
  end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic               clk,
  input  logic               i_rst_n,
  input  core_pkg::xlen_t    i_rs1_val_e,
  input  core_pkg::xlen_t    i_rs2_val_e,
  input  core_pkg::xlen_t    i_imm_e,
  input  core_pkg::addr_t    i_pc_e,
  input  core_pkg::reg_idx_t i_rd_e,
  input  core_pkg::alu_op_e  i_alu_op_e,
  input  logic               i_alu_src_imm_e,
  input  logic               i_is_load_e,
  input  logic               i_is_store_e,
  input  logic               i_is_branch_e,
  input  logic [2:0]         i_funct3_e,
  input  logic               i_reg_write_e,
  input  logic               i_link_e,
  input  core_pkg::fwd_sel_e i_fwd_a,
  input  core_pkg::fwd_sel_e i_fwd_b,
  input  core_pkg::xlen_t    i_mem_result,
  input  core_pkg::xlen_t    i_wb_data,
  output logic               o_br_taken,
  output core_pkg::addr_t    o_br_target,
  output core_pkg::xlen_t    o_alu_out_m,
  output core_pkg::xlen_t    o_store_data_m,
  output core_pkg::reg_idx_t o_rd_m,
  output logic               o_reg_write_m,
  output logic               o_is_load_m,
  output logic               o_is_store_m
);

  core_pkg::xlen_t op_a, op_b, alu_b, alu_out, result;
  logic            br_cond;

  function automatic core_pkg::xlen_t fwd_pick(input core_pkg::fwd_sel_e sel,
                                               input core_pkg::xlen_t reg_val,
                                               input core_pkg::xlen_t mem_val,
                                               input core_pkg::xlen_t wb_val);
    case (sel)
      core_pkg::FWD_MEM: return mem_val;
      core_pkg::FWD_WB:  return wb_val;
      default:           return reg_val;
    endcase
  endfunction

  assign op_a  = fwd_pick(i_fwd_a, i_rs1_val_e, i_mem_result, i_wb_data);
  assign op_b  = fwd_pick(i_fwd_b, i_rs2_val_e, i_mem_result, i_wb_data);
  assign alu_b = i_alu_src_imm_e ? i_imm_e : op_b;

  always_comb begin
    case (i_alu_op_e)
      core_pkg::SUB:    alu_out = op_a - alu_b;
      core_pkg::AND:    alu_out = op_a & alu_b;
      core_pkg::OR:     alu_out = op_a | alu_b;
      core_pkg::XOR:    alu_out = op_a ^ alu_b;
      core_pkg::SLT:    alu_out = {{(core_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      core_pkg::SLTU:   alu_out = {{(core_pkg::XLEN-1){1'b0}}, op_a < alu_b};
      core_pkg::SLL:    alu_out = op_a << alu_b[4:0];
      core_pkg::SRL:    alu_out = op_a >> alu_b[4:0];
      core_pkg::SRA:    alu_out = $signed(op_a) >>> alu_b[4:0];
      core_pkg::PASS_B: alu_out = alu_b;
      default:          alu_out = op_a + alu_b;
    endcase
  end

  // branch compares the two register operands, never the immediate
  always_comb begin
    case (i_funct3_e)
      core_pkg::F3_BEQ: br_cond = (op_a == op_b);
      core_pkg::F3_BNE: br_cond = (op_a != op_b);
      core_pkg::F3_BLT: br_cond = ($signed(op_a) < $signed(op_b));
      core_pkg::F3_BGE: br_cond = ($signed(op_a) >= $signed(op_b));
      default:          br_cond = 1'b0;
    endcase
  end

  assign o_br_taken  = i_is_branch_e && br_cond;
  assign o_br_target = i_pc_e + i_imm_e;

  // jal link value
  assign result = i_link_e ? i_pc_e + 32'd4 : alu_out;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_reg_write_m <= 1'b0;
      o_is_load_m   <= 1'b0;
      o_is_store_m  <= 1'b0;
    end else begin
      o_reg_write_m <= i_reg_write_e;
      o_is_load_m   <= i_is_load_e;
      o_is_store_m  <= i_is_store_e;
    end
  end

  always_ff @(posedge clk) begin
    o_alu_out_m    <= result;
    o_store_data_m <= op_b;
    o_rd_m         <= i_rd_e;
  end

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
  input  logic               clk,
  input  logic               i_rst_n,
  input  core_pkg::xlen_t    i_alu_out_m,
  input  core_pkg::xlen_t    i_store_data_m,
  input  core_pkg::reg_idx_t i_rd_m,
  input  logic               i_reg_write_m,
  input  logic               i_is_load_m,
  input  logic               i_is_store_m,
  input  core_pkg::xlen_t    i_mem_rdata,
  output core_pkg::addr_t    o_mem_addr,
  output core_pkg::xlen_t    o_mem_wdata,
  output logic               o_mem_we,
  output core_pkg::xlen_t    o_mem_result,
  output logic               o_wb_we,
  output core_pkg::reg_idx_t o_wb_rd,
  output core_pkg::xlen_t    o_wb_data
);

  // word access only with the alu result as byte address
  assign o_mem_addr  = i_alu_out_m;
  assign o_mem_wdata = i_store_data_m;
  assign o_mem_we    = i_is_store_m;

  // read data arrives in the same cycle
  assign o_mem_result = i_is_load_m ? i_mem_rdata : i_alu_out_m;

  // mem/wb register
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_wb_we <= 1'b0;
    end else begin
      o_wb_we <= i_reg_write_m;
    end
  end

  always_ff @(posedge clk) begin
    o_wb_rd   <= i_rd_m;
    o_wb_data <= o_mem_result;
  end

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
  input  core_pkg::reg_idx_t i_rs1_d,
  input  core_pkg::reg_idx_t i_rs2_d,
  input  core_pkg::reg_idx_t i_rs1_e,
  input  core_pkg::reg_idx_t i_rs2_e,
  input  core_pkg::reg_idx_t i_rd_e,
  input  logic               i_is_load_e,
  input  logic               i_jal_taken,
  input  logic               i_br_taken,
  input  core_pkg::reg_idx_t i_rd_m,
  input  logic               i_reg_write_m,
  input  core_pkg::reg_idx_t i_rd_w,
  input  logic               i_reg_write_w,
  output logic               o_stall_f,
  output logic               o_stall_d,
  output logic               o_flush_d,
  output logic               o_flush_e,
  output core_pkg::fwd_sel_e o_fwd_a,
  output core_pkg::fwd_sel_e o_fwd_b
);

  logic load_use;

  // mem stage is newer, so it is checked first
  function automatic core_pkg::fwd_sel_e fwd_for(input core_pkg::reg_idx_t rs,
                                                 input core_pkg::reg_idx_t rd_m, input logic we_m,
                                                 input core_pkg::reg_idx_t rd_w, input logic we_w);
    if (rs == '0) return core_pkg::FWD_NONE;
    if (we_m && rd_m == rs) return core_pkg::FWD_MEM;
    if (we_w && rd_w == rs) return core_pkg::FWD_WB;
    return core_pkg::FWD_NONE;
  endfunction

  assign o_fwd_a = fwd_for(i_rs1_e, i_rd_m, i_reg_write_m, i_rd_w, i_reg_write_w);
  assign o_fwd_b = fwd_for(i_rs2_e, i_rd_m, i_reg_write_m, i_rd_w, i_reg_write_w);

  assign load_use = i_is_load_e && (i_rd_e != '0) && (i_rd_e == i_rs1_d || i_rd_e == i_rs2_d);

  assign o_stall_f = load_use;
  assign o_stall_d = load_use;
  // a stalled jal redirects once the bubble has passed
  assign o_flush_d = i_br_taken || (i_jal_taken && !load_use);
  assign o_flush_e = i_br_taken || load_use;

endmodule

// ==== logic/core_top.sv ====
`timescale 1ns/1ps

module core_top (
  input  logic            clk,
  input  logic            i_rst_n,
  input  core_pkg::inst_t i_inst,
  output core_pkg::addr_t o_pc,
  input  core_pkg::xlen_t i_mem_rdata,
  output core_pkg::addr_t o_mem_addr,
  output core_pkg::xlen_t o_mem_wdata,
  output logic            o_mem_we
);

  // hazard controls
  logic               stall_f, stall_d, flush_d, flush_e;
  core_pkg::fwd_sel_e fwd_a, fwd_b;

  // fetch and decode
  core_pkg::inst_t    inst_d;
  core_pkg::addr_t    pc_d, jal_target, br_target;
  core_pkg::reg_idx_t rs1_d, rs2_d;
  logic               jal_taken, br_taken;

  // execute
  core_pkg::xlen_t    rs1_val_e, rs2_val_e, imm_e;
  core_pkg::addr_t    pc_e;
  core_pkg::reg_idx_t rd_e, rs1_e, rs2_e;
  core_pkg::alu_op_e  alu_op_e;
  logic [2:0]         funct3_e;
  logic               alu_src_imm_e, is_load_e, is_store_e, is_branch_e, reg_write_e, link_e;

  // memory and writeback
  core_pkg::xlen_t    alu_out_m, store_data_m, mem_result, wb_data;
  core_pkg::reg_idx_t rd_m, wb_rd;
  logic               reg_write_m, is_load_m, is_store_m, wb_we;

  fetch_stage fetch_i (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_stall_f(stall_f), .i_stall_d(stall_d), .i_flush_d(flush_d),
    .i_jal_taken(jal_taken), .i_jal_target(jal_target),
    .i_br_taken(br_taken), .i_br_target(br_target),
    .i_inst(i_inst),
    .o_pc(o_pc), .o_inst_d(inst_d), .o_pc_d(pc_d)
  );

  decode_stage decode_i (
    .clk(clk), .i_rst_n(i_rst_n), .i_flush_e(flush_e),
    .i_inst_d(inst_d), .i_pc_d(pc_d),
    .i_wb_we(wb_we), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
    .o_rs1_d(rs1_d), .o_rs2_d(rs2_d),
    .o_jal_taken(jal_taken), .o_jal_target(jal_target),
    .o_rs1_val_e(rs1_val_e), .o_rs2_val_e(rs2_val_e), .o_imm_e(imm_e), .o_pc_e(pc_e),
    .o_rd_e(rd_e), .o_rs1_e(rs1_e), .o_rs2_e(rs2_e),
    .o_alu_op_e(alu_op_e), .o_alu_src_imm_e(alu_src_imm_e),
    .o_is_load_e(is_load_e), .o_is_store_e(is_store_e), .o_is_branch_e(is_branch_e),
    .o_funct3_e(funct3_e), .o_reg_write_e(reg_write_e), .o_link_e(link_e)
  );

  execute_stage execute_i (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_rs1_val_e(rs1_val_e), .i_rs2_val_e(rs2_val_e), .i_imm_e(imm_e), .i_pc_e(pc_e),
    .i_rd_e(rd_e), .i_alu_op_e(alu_op_e), .i_alu_src_imm_e(alu_src_imm_e),
    .i_is_load_e(is_load_e), .i_is_store_e(is_store_e), .i_is_branch_e(is_branch_e),
    .i_funct3_e(funct3_e), .i_reg_write_e(reg_write_e), .i_link_e(link_e),
    .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
    .i_mem_result(mem_result), .i_wb_data(wb_data),
    .o_br_taken(br_taken), .o_br_target(br_target),
    .o_alu_out_m(alu_out_m), .o_store_data_m(store_data_m), .o_rd_m(rd_m),
    .o_reg_write_m(reg_write_m), .o_is_load_m(is_load_m), .o_is_store_m(is_store_m)
  );

  memory_stage memory_i (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_alu_out_m(alu_out_m), .i_store_data_m(store_data_m), .i_rd_m(rd_m),
    .i_reg_write_m(reg_write_m), .i_is_load_m(is_load_m), .i_is_store_m(is_store_m),
    .i_mem_rdata(i_mem_rdata),
    .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata), .o_mem_we(o_mem_we),
    .o_mem_result(mem_result),
    .o_wb_we(wb_we), .o_wb_rd(wb_rd), .o_wb_data(wb_data)
  );

  hazard_unit hazard_i (
    .i_rs1_d(rs1_d), .i_rs2_d(rs2_d),
    .i_rs1_e(rs1_e), .i_rs2_e(rs2_e), .i_rd_e(rd_e), .i_is_load_e(is_load_e),
    .i_jal_taken(jal_taken), .i_br_taken(br_taken),
    .i_rd_m(rd_m), .i_reg_write_m(reg_write_m), .i_rd_w(wb_rd), .i_reg_write_w(wb_we),
    .o_stall_f(stall_f), .o_stall_d(stall_d), .o_flush_d(flush_d), .o_flush_e(flush_e),
    .o_fwd_a(fwd_a), .o_fwd_b(fwd_b)
  );

endmodule

// ==== tb/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

  localparam int NUM_PROGS      = 20;
  localparam int PROG_LEN       = 40;
  localparam int NUM_INIT       = 7;
  localparam int BODY_END       = PROG_LEN - 8;
  localparam int IMEM_WORDS     = 64;
  localparam int DMEM_WORDS     = 256;
  localparam int RST_CYCLES     = 4;
  localparam int DRAIN_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = NUM_PROGS * (PROG_LEN * 4 + 60 + RST_CYCLES + DRAIN_CYCLES + 2);
  localparam logic [31:0] DUMP_BASE = 32'h0000_0100;

  // instruction kinds of the generator
  localparam int K_OP  = 0;
  localparam int K_OPI = 1;
  localparam int K_LUI = 2;
  localparam int K_LW  = 3;
  localparam int K_SW  = 4;
  localparam int K_BR  = 5;
  localparam int K_JAL = 6;

  // funct3 choices for addi/slti/xori/ori/andi and beq/bne/blt/bge
  localparam logic [14:0] OPI_F3 = {3'd7, 3'd6, 3'd4, 3'd2, 3'd0};
  localparam logic [11:0] BR_F3  = {3'd5, 3'd4, 3'd1, 3'd0};

  logic            clk;
  logic            rst_n;
  core_pkg::inst_t inst;
  core_pkg::addr_t pc, inst_off, mem_addr;
  core_pkg::xlen_t mem_rdata, mem_wdata;
  logic            mem_we;

  core_pkg::inst_t imem [IMEM_WORDS];
  core_pkg::xlen_t dmem [DMEM_WORDS];
  core_pkg::xlen_t m_dmem [DMEM_WORDS];
  core_pkg::xlen_t m_regs [8];

  // current program with one entry per slot
  int         kind_a [PROG_LEN];
  logic [2:0] f3_a   [PROG_LEN];
  logic       alt_a  [PROG_LEN];
  logic [4:0] rd_a   [PROG_LEN];
  logic [4:0] rs1_a  [PROG_LEN];
  logic [4:0] rs2_a  [PROG_LEN];
  logic [31:0] imm_a [PROG_LEN];

  core_pkg::addr_t exp_addr [$];
  core_pkg::xlen_t exp_data [$];

  int seed         = 50428;
  int errors       = 0;
  int cur_prog     = 0;
  int obs_count    = 0;
  int total_stores = 0;

  core_top dut_i (
    .clk(clk), .i_rst_n(rst_n),
    .i_inst(inst), .o_pc(pc),
    .i_mem_rdata(mem_rdata), .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata), .o_mem_we(mem_we)
  );

  always #4 clk = ~clk;

  // nop outside the program window
  assign inst_off = pc - core_pkg::RESET_PC;
  assign inst     = (inst_off[31:2] < IMEM_WORDS) ? imem[inst_off[7:2]] : core_pkg::NOP_INST;

  // combinational data memory read
  assign mem_rdata = dmem[mem_addr[9:2]];

  always @(posedge clk) begin
    if (rst_n && mem_we) begin
      dmem[mem_addr[9:2]] <= mem_wdata;
    end
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic core_pkg::xlen_t fill_word(input core_pkg::addr_t addr);
    return (addr * 32'h9E37_79B9) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  // rv32i integer semantics with alt selecting sub or sra
  function automatic core_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                              input core_pkg::xlen_t a, input core_pkg::xlen_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic taken_ref(input logic [2:0] f3, input core_pkg::xlen_t a,
                                     input core_pkg::xlen_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      default: return $signed(a) >= $signed(b);
    endcase
  endfunction

  function automatic core_pkg::inst_t encode(input int i);
    logic [31:0] imm;
    imm = imm_a[i];
    case (kind_a[i])
      K_OP:  return {alt_a[i] ? 7'b0100000 : 7'b0000000, rs2_a[i], rs1_a[i], f3_a[i], rd_a[i],
                     core_pkg::OPC_OP};
      K_OPI: return {imm[11:0], rs1_a[i], f3_a[i], rd_a[i], core_pkg::OPC_OP_IMM};
      K_LUI: return {imm[31:12], rd_a[i], core_pkg::OPC_LUI};
      K_LW:  return {imm[11:0], rs1_a[i], 3'b010, rd_a[i], core_pkg::OPC_LOAD};
      K_SW:  return {imm[11:5], rs2_a[i], rs1_a[i], 3'b010, imm[4:0], core_pkg::OPC_STORE};
      K_BR:  return {imm[12], imm[10:5], rs2_a[i], rs1_a[i], f3_a[i], imm[4:1], imm[11],
                     core_pkg::OPC_BRANCH};
      default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd_a[i], core_pkg::OPC_JAL};
    endcase
  endfunction

  // lui prologue, random body, register dump and self-jump
  task automatic build_program();
    int          sel;
    int          hop;
    logic [4:0]  last_rd;
    logic [31:0] r;
    last_rd = 5'd1;
    for (int i = 0; i < PROG_LEN; i++) begin
      r        = $random(seed);
      kind_a[i] = K_OP;
      f3_a[i]  = 3'd0;
      alt_a[i] = 1'b0;
      rd_a[i]  = 5'(1 + rand_below(7));
      // half of the sources reuse the last result
      rs1_a[i] = (rand_below(2) == 0) ? last_rd : 5'(1 + rand_below(7));
      rs2_a[i] = 5'(1 + rand_below(7));
      imm_a[i] = {{20{r[11]}}, r[11:0]};
      if (i < NUM_INIT) begin
        kind_a[i] = K_LUI;
        rd_a[i]   = 5'(i + 1);
        imm_a[i]  = {r[31:12], 12'b0};
      end else if (i == PROG_LEN - 1) begin
        kind_a[i] = K_JAL;
        rd_a[i]   = 5'd0;
        imm_a[i]  = '0;
      end else if (i >= BODY_END) begin
        kind_a[i] = K_SW;
        rs1_a[i]  = 5'd0;
        rs2_a[i]  = 5'(i - BODY_END + 1);
        imm_a[i]  = DUMP_BASE + 4 * (i - BODY_END);
      end else begin
        sel = rand_below(11);
        hop = 1 + rand_below(4);
        // never jump past the dump sequence
        if (i + hop > BODY_END) hop = BODY_END - i;
        case (sel)
          0, 1, 2: begin
            f3_a[i]  = 3'(rand_below(8));
            alt_a[i] = (f3_a[i] == 3'd0 || f3_a[i] == 3'd5) && (rand_below(2) == 1);
          end
          3, 4, 5: begin
            kind_a[i] = K_OPI;
            f3_a[i]   = OPI_F3[3 * rand_below(5) +: 3];
          end
          6: begin
            kind_a[i] = K_LUI;
            imm_a[i]  = {r[31:12], 12'b0};
          end
          7: begin
            kind_a[i] = K_LW;
            rs1_a[i]  = 5'd0;
            imm_a[i]  = 4 * rand_below(64);
          end
          8: begin
            kind_a[i] = K_SW;
            rs2_a[i]  = rs1_a[i];
            rs1_a[i]  = 5'd0;
            imm_a[i]  = 4 * rand_below(64);
          end
          9: begin
            kind_a[i] = K_BR;
            f3_a[i]   = BR_F3[3 * rand_below(4) +: 3];
            imm_a[i]  = 4 * hop;
          end
          default: begin
            kind_a[i] = K_JAL;
            imm_a[i]  = 4 * hop;
          end
        endcase
      end
      if (kind_a[i] != K_SW && kind_a[i] != K_BR) last_rd = rd_a[i];
      imem[i] = encode(i);
    end
  endtask

  task automatic fill_data_memories();
    for (int k = 0; k < DMEM_WORDS; k++) begin
      dmem[k]   = fill_word(4 * k);
      m_dmem[k] = fill_word(4 * k);
    end
  endtask

  // runs the program in order and records every store
  task automatic run_model();
    int              idx;
    int              next;
    core_pkg::xlen_t a, b, addr;
    for (int k = 0; k < 8; k++) m_regs[k] = '0;
    exp_addr.delete();
    exp_data.delete();
    idx = 0;
    while (!(kind_a[idx] == K_JAL && imm_a[idx] == 0)) begin
      a    = m_regs[rs1_a[idx]];
      b    = m_regs[rs2_a[idx]];
      addr = a + imm_a[idx];
      next = idx + 1;
      case (kind_a[idx])
        K_OP:  m_regs[rd_a[idx]] = alu_ref(f3_a[idx], alt_a[idx], a, b);
        K_OPI: m_regs[rd_a[idx]] = alu_ref(f3_a[idx], 1'b0, a, imm_a[idx]);
        K_LUI: m_regs[rd_a[idx]] = imm_a[idx];
        K_LW:  m_regs[rd_a[idx]] = m_dmem[addr[9:2]];
        K_SW: begin
          m_dmem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        K_BR: begin
          if (taken_ref(f3_a[idx], a, b)) next = idx + imm_a[idx] / 4;
        end
        default: begin
          m_regs[rd_a[idx]] = core_pkg::RESET_PC + 4 * (idx + 1);
          next = idx + imm_a[idx] / 4;
        end
      endcase
      m_regs[0] = '0;
      idx = next;
    end
  endtask

  // store monitor in program order
  always @(negedge clk) begin
    if (rst_n && mem_we) begin
      if (obs_count >= exp_addr.size()) begin
        $display("error at %0t: program %0d stored more words than expected", $time, cur_prog);
        errors++;
      end else begin
        if (mem_addr !== exp_addr[obs_count]) begin
          $display("mismatch at %0t: o_mem_addr got %h expected %h",
                   $time, mem_addr, exp_addr[obs_count]);
          errors++;
        end
        if (mem_wdata !== exp_data[obs_count]) begin
          $display("mismatch at %0t: o_mem_wdata got %h expected %h",
                   $time, mem_wdata, exp_data[obs_count]);
          errors++;
        end
      end
      obs_count++;
      total_stores++;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: program %0d did not finish its stores, %0d errors", cur_prog, errors);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    for (int k = 0; k < IMEM_WORDS; k++) imem[k] = core_pkg::NOP_INST;
    fill_data_memories();
    for (int p = 0; p < NUM_PROGS; p++) begin
      @(posedge clk);
      rst_n <= 1'b0;
      // new program is loaded while the core is held in reset
      cur_prog = p;
      build_program();
      fill_data_memories();
      run_model();
      obs_count = 0;
      repeat (RST_CYCLES - 1) begin
        @(posedge clk);
        @(negedge clk);
        if (pc !== core_pkg::RESET_PC) begin
          $display("mismatch at %0t: o_pc got %h expected %h", $time, pc, core_pkg::RESET_PC);
          errors++;
        end
        if (mem_we !== 1'b0) begin
          $display("mismatch at %0t: o_mem_we got %b expected 0", $time, mem_we);
          errors++;
        end
      end
      @(posedge clk);
      rst_n <= 1'b1;
      while (obs_count < exp_addr.size()) begin
        @(negedge clk);
      end
      // extra stores after the dump show up here
      repeat (DRAIN_CYCLES) @(negedge clk);
    end
    $display("programs: %0d, stores: %0d, errors: %0d", NUM_PROGS, total_stores, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
logic/core_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/core_top.sv
tb/tb_core.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - logic/core_pkg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/hazard_unit.sv
  - logic/core_top.sv
  - target: simulation
    files:
      - tb/tb_core.sv
